//--- design/blkcpy_pkg.sv
package blkcpy_pkg;

   // memory geometry
   parameter int ADDR_W = 8;               // 256 words
   parameter int DATA_W = 32;              // word width
   parameter int MEM_DEPTH = 1 << ADDR_W;  // words in the ram

   // one access on a ram port
   // stb qualifies the cycle, wre turns the read into a write
   typedef struct packed {
      logic              stb;  // chip select
      logic              wre;  // write enable
      logic [ADDR_W-1:0] adr;  // word address
      logic [DATA_W-1:0] dat;  // write data
   } mem_port_t;

   // copy request from the host
   // len is one bit wider so a full 256-word copy fits
   typedef struct packed {
      logic [ADDR_W-1:0] src;  // first source word
      logic [ADDR_W-1:0] dst;  // first destination word
      logic [ADDR_W:0]   len;  // word count, 0 means no copy
   } copy_cmd_t;

   // copy sequencer states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,  // waiting for start
      ST_RUN   = 2'd1,  // one read per cycle
      ST_DRAIN = 2'd2   // last write still in flight
   } copy_state_e;

endpackage

//--- design/dpsram_rbw.sv
`timescale 1ns/1ps

// two ports on one clock, both read before they write
module dpsram_rbw
   import blkcpy_pkg::*;
(
   input  logic              clk_i,
   input  mem_port_t         a_i,      // host or engine read port
   output logic [DATA_W-1:0] a_dat_o,  // registered read data, port a
   input  mem_port_t         x_i,      // engine write port
   output logic [DATA_W-1:0] x_dat_o   // registered read data, port x
);

   logic [DATA_W-1:0] mem [MEM_DEPTH];  // storage, no reset
   logic [DATA_W-1:0] a_q;              // port a output latch
   logic [DATA_W-1:0] x_q;              // port x output latch

   // both ports share one process since they share one clock
   // same-address collisions between a and x are left undefined
   always_ff @(posedge clk_i) begin
      if (a_i.stb) begin
         a_q <= mem[a_i.adr];              // old word, even on a write
         if (a_i.wre)
            mem[a_i.adr] <= a_i.dat;
      end
      if (x_i.stb) begin
         x_q <= mem[x_i.adr];              // old word
         if (x_i.wre)
            mem[x_i.adr] <= x_i.dat;
      end
   end

   assign a_dat_o = a_q;  // holds until the next port a strobe
   assign x_dat_o = x_q;

endmodule

//--- design/copy_counter.sv
`timescale 1ns/1ps

// address and length bookkeeping for one copy
module copy_counter
   import blkcpy_pkg::*;
(
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  copy_cmd_t         cmd_i,     // sampled on load
   input  logic              load_i,    // capture a new command
   input  logic              step_i,    // one word issued
   output logic [ADDR_W-1:0] src_o,     // current read address
   output logic [ADDR_W-1:0] dst_o,     // destination of the current read
   output logic              last_o     // one word left
);

   logic [ADDR_W-1:0] src_q;
   logic [ADDR_W-1:0] dst_q;
   logic [ADDR_W:0]   cnt_q;  // words still to be read

   // source side advances with every read
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         src_q <= '0;
      end else if (load_i) begin
         src_q <= cmd_i.src;
      end else if (step_i) begin
         src_q <= src_q + 1'b1;  // wraps at the top of memory
      end
   end

   // destination tracks the source one for one
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dst_q <= '0;
      end else if (load_i) begin
         dst_q <= cmd_i.dst;
      end else if (step_i) begin
         dst_q <= dst_q + 1'b1;
      end
   end

   // remaining length
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= '0;
      end else if (load_i) begin
         cnt_q <= cmd_i.len;
      end else if (step_i && cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;  // stops at zero after the final step
      end
   end

   assign src_o  = src_q;
   assign dst_o  = dst_q;
   assign last_o = (cnt_q == (ADDR_W+1)'(1));  // current read is the final one

endmodule

//--- design/copy_fsm.sv
`timescale 1ns/1ps

// sequences one copy: load, len reads, one trailing write
module copy_fsm
   import blkcpy_pkg::*;
(
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic start_i,     // one-cycle request
   input  logic len_zero_i,  // request carries no words
   input  logic last_i,      // counter at its final word
   output logic load_o,      // capture the command
   output logic step_o,      // advance the counters
   output logic rd_en_o,     // engine owns port a
   output logic busy_o,      // copy in progress
   output logic done_o       // copy finished, one cycle
);

   copy_state_e state_q;
   copy_state_e state_d;
   logic        done_q;
   logic        go;  // accepted start

   // a zero-length start never leaves idle
   assign go = (state_q == ST_IDLE) && start_i && !len_zero_i;

   // next state
   always_comb begin
      state_d = state_q;  // hold by default
      case (state_q)
         ST_IDLE: begin
            if (go)
               state_d = ST_RUN;
         end
         ST_RUN: begin
            if (last_i)
               state_d = ST_DRAIN;  // final read issued this cycle
         end
         ST_DRAIN: begin
            state_d = ST_IDLE;  // final write lands at this edge
         end
         default: begin
            state_d = ST_IDLE;  // unused encoding
         end
      endcase
   end

   // state and done registers
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
         done_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         done_q  <= (state_q == ST_DRAIN);  // rises as busy falls
      end
   end

   assign load_o  = go;
   assign step_o  = (state_q == ST_RUN);    // one word per cycle
   assign rd_en_o = (state_q == ST_RUN);
   assign busy_o  = (state_q != ST_IDLE);   // run and drain
   assign done_o  = done_q;

endmodule

//--- design/mem_port_steer.sv
`timescale 1ns/1ps

// port a mux plus the write stage that feeds port x
module mem_port_steer
   import blkcpy_pkg::*;
(
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  mem_port_t         host_i,     // host request
   input  logic              rd_en_i,    // engine read this cycle
   input  logic [ADDR_W-1:0] src_i,      // engine read address
   input  logic [ADDR_W-1:0] dst_i,      // where that read goes
   input  logic [DATA_W-1:0] rd_dat_i,   // port a read data
   output mem_port_t         port_a_o,
   output mem_port_t         port_x_o
);

   logic              wr_vld_q;  // write pending on port x
   logic [ADDR_W-1:0] wr_adr_q;  // its destination, no reset
   logic              host_blk;  // copy owns the memory

   // write stage, second half of the copy pipeline
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_vld_q <= 1'b0;
      end else begin
         wr_vld_q <= rd_en_i;  // one cycle behind the read
      end
   end

   always_ff @(posedge clk_i) begin
      wr_adr_q <= dst_i;
   end

   // run cycles have rd_en, the drain cycle has only the pending write
   assign host_blk = rd_en_i | wr_vld_q;

   // port a owner
   always_comb begin
      if (rd_en_i) begin
         port_a_o.stb = 1'b1;
         port_a_o.wre = 1'b0;  // engine only reads here
         port_a_o.adr = src_i;
         port_a_o.dat = '0;
      end else if (host_blk) begin
         port_a_o = '0;  // host dropped during drain
      end else begin
         port_a_o = host_i;
      end
   end

   // port x always writes, data straight from last cycle's read
   assign port_x_o.stb = wr_vld_q;
   assign port_x_o.wre = wr_vld_q;
   assign port_x_o.adr = wr_adr_q;
   assign port_x_o.dat = rd_dat_i;

endmodule

//--- design/blkcpy_top.sv
`timescale 1ns/1ps

// block-copy engine around a read-before-write dual-port ram
module blkcpy_top
   import blkcpy_pkg::*;
(
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  mem_port_t         host_i,      // host access on port a
   output logic [DATA_W-1:0] host_dat_o,  // host read data
   input  logic              start_i,     // copy request pulse
   input  copy_cmd_t         cmd_i,       // valid with start_i
   output logic              busy_o,
   output logic              done_o
);

   // fsm to counter and steering
   logic load;
   logic step;
   logic rd_en;

   // counter outputs
   logic [ADDR_W-1:0] src;
   logic [ADDR_W-1:0] dst;
   logic              last;

   // ram side
   mem_port_t         port_a;
   mem_port_t         port_x;
   logic [DATA_W-1:0] dat_a;  // shared by host and write stage
   logic              len_zero;

   assign len_zero = (cmd_i.len == '0);

   copy_fsm u_copy_fsm (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .start_i    (start_i),
      .len_zero_i (len_zero),
      .last_i     (last),
      .load_o     (load),
      .step_o     (step),
      .rd_en_o    (rd_en),
      .busy_o     (busy_o),
      .done_o     (done_o)
   );

   copy_counter u_copy_counter (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .cmd_i    (cmd_i),
      .load_i   (load),
      .step_i   (step),
      .src_o    (src),
      .dst_o    (dst),
      .last_o   (last)
   );

   mem_port_steer u_mem_port_steer (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .host_i   (host_i),
      .rd_en_i  (rd_en),
      .src_i    (src),
      .dst_i    (dst),
      .rd_dat_i (dat_a),
      .port_a_o (port_a),
      .port_x_o (port_x)
   );

   // x read data not needed, port x only writes
   dpsram_rbw u_dpsram_rbw (
      .clk_i   (clk_i),
      .a_i     (port_a),
      .a_dat_o (dat_a),
      .x_i     (port_x),
      .x_dat_o ()
   );

   assign host_dat_o = dat_a;

endmodule

//--- verification/blkcpy_tb.sv
`timescale 1ns/1ps

// trace-driven testbench for the block-copy engine
module blkcpy_tb
   import blkcpy_pkg::*;
();

   logic              clk_i;
   logic              arst_n_i;
   mem_port_t         host_i;
   logic [DATA_W-1:0] host_dat_o;
   logic              start_i;
   copy_cmd_t         cmd_i;
   logic              busy_o;
   logic              done_o;

   // trace operations, one entry per line of the file
   logic [7:0]  op_q [$];
   logic [31:0] fa_q [$];
   logic [31:0] fb_q [$];
   logic [31:0] fc_q [$];
   logic [31:0] fd_q [$];
   logic [31:0] fe_q [$];

   logic [DATA_W-1:0] model [MEM_DEPTH];  // expected ram contents

   int cycles = 0;
   int limit = 200;
   bit limit_on = 1'b0;
   bit trace_ok = 1'b1;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int failed_tests = 0;
   int test_errs = 0;  // errors in the running test
   int rnd;

   blkcpy_top u_blkcpy_top (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .host_i     (host_i),
      .host_dat_o (host_dat_o),
      .start_i    (start_i),
      .cmd_i      (cmd_i),
      .busy_o     (busy_o),
      .done_o     (done_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;  // 40 ns period
   end

   // watchdog
   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (limit_on && cycles > limit) begin
         $display("timeout after %0d cycles, the DUT never finished the trace", cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // inputs change 2 ns after the edge, outputs already settled there
   task step_clk;
      @(posedge clk_i);
      #2;
   endtask

   task automatic check_word(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         test_errs++;
         errors++;
      end
   endtask

   // one write strobe, old word comes back on host_dat_o
   task automatic host_write(logic [ADDR_W-1:0] adr, logic [DATA_W-1:0] dat,
                             output logic [DATA_W-1:0] old);
      host_i.stb = 1'b1;
      host_i.wre = 1'b1;
      host_i.adr = adr;
      host_i.dat = dat;
      step_clk;
      old = host_dat_o;
      host_i = '0;
      model[adr] = dat;
   endtask

   task automatic host_read(logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] dat);
      host_i.stb = 1'b1;
      host_i.wre = 1'b0;
      host_i.adr = adr;
      host_i.dat = '0;
      step_clk;
      dat = host_dat_o;  // registered, valid after the sampling edge
      host_i = '0;
   endtask

   // copy with busy/done timing check, optional host write while busy
   task automatic run_copy(string name, logic [ADDR_W-1:0] src, logic [ADDR_W-1:0] dst,
                           logic [ADDR_W:0] len, bit poke, logic [ADDR_W-1:0] padr,
                           logic [DATA_W-1:0] pdat);
      int n;
      int k;
      logic [DATA_W-1:0] words [$];
      cmd_i.src = src;
      cmd_i.dst = dst;
      cmd_i.len = len;
      start_i = 1'b1;
      step_clk;  // start edge
      start_i = 1'b0;
      cmd_i = '0;
      n = 1;
      while (!done_o && n <= len + 4) begin
         checks++;
         if (busy_o !== 1'b1) begin
            $display("FAIL %s busy_o at cycle %0d expected 1 actual %b", name, n, busy_o);
            test_errs++;
            errors++;
         end
         if (poke) begin
            host_i.stb = 1'b1;  // held through run and drain, must be dropped
            host_i.wre = 1'b1;
            host_i.adr = padr;
            host_i.dat = pdat;
         end else begin
            host_i = '0;
         end
         step_clk;
         n++;
      end
      host_i = '0;
      checks++;
      if (!done_o) begin
         $display("%s: done_o never pulsed after the copy started", name);
         test_errs++;
         errors++;
      end else begin
         if (n != len + 2) begin
            $display("FAIL %s done cycle expected %0d actual %0d", name, len + 2, n);
            test_errs++;
            errors++;
         end
         if (busy_o !== 1'b0) begin
            $display("FAIL %s busy_o with done expected 0 actual %b", name, busy_o);
            test_errs++;
            errors++;
         end
         step_clk;
         if (done_o !== 1'b0) begin
            $display("FAIL %s done_o width expected 0 actual %b", name, done_o);
            test_errs++;
            errors++;
         end
      end
      // dst takes the source words, ranges never overlap
      for (k = 0; k < len; k++)
         words.push_back(model[src + k[ADDR_W-1:0]]);
      for (k = 0; k < len; k++)
         model[dst + k[ADDR_W-1:0]] = words[k];
   endtask

   // start with len 0, nothing may move
   task automatic zero_start(string name, logic [ADDR_W-1:0] src, logic [ADDR_W-1:0] dst);
      int k;
      logic [DATA_W-1:0] got;
      host_write(dst, ~model[src], got);  // dst differs from src, a stray copy shows
      cmd_i.src = src;
      cmd_i.dst = dst;
      cmd_i.len = '0;
      start_i = 1'b1;
      step_clk;
      start_i = 1'b0;
      cmd_i = '0;
      for (k = 0; k < 4; k++) begin
         checks++;
         if (busy_o !== 1'b0 || done_o !== 1'b0) begin
            $display("FAIL %s busy/done expected 00 actual %b%b", name, busy_o, done_o);
            test_errs++;
            errors++;
         end
         step_clk;
      end
      host_read(dst, got);
      check_word(name, model[dst], got);
   endtask

   // trace file into queues, '#' lines are comments
   task load_trace;
      integer fd;
      integer n;
      integer nf;
      logic [7:0] op;
      logic [31:0] a, b, c, d, e;
      reg [8*200-1:0] rest;
      bit fin;
      fd = $fopen("verification/blkcpy_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open trace file verification/blkcpy_trace.txt");
         trace_ok = 1'b0;
      end else begin
         fin = 1'b0;
         while (!fin) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
               fin = 1'b1;  // end of file
            end else if (op == "#") begin
               n = $fgets(rest, fd);
            end else begin
               a = 0;
               b = 0;
               c = 0;
               d = 0;
               e = 0;
               case (op)
                  "W", "R", "X", "M": begin
                     nf = 2;
                     n = $fscanf(fd, "%h %h", a, b);
                  end
                  "U", "C", "N": begin
                     nf = 3;
                     n = $fscanf(fd, "%h %h %h", a, b, c);
                  end
                  "P": begin
                     nf = 5;
                     n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                  end
                  default: begin
                     nf = 0;
                     n = 1;
                  end
               endcase
               if (n != nf) begin
                  $display("bad trace line %0d with op %c", op_q.size(), op);
                  trace_ok = 1'b0;
                  fin = 1'b1;
               end else begin
                  op_q.push_back(op);
                  fa_q.push_back(a);
                  fb_q.push_back(b);
                  fc_q.push_back(c);
                  fd_q.push_back(d);
                  fe_q.push_back(e);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // rough cycle length of one trace operation
   function automatic int op_cost(logic [7:0] op, logic [31:0] b, logic [31:0] c);
      case (op)
         "X", "M": return 2 * b + 2;
         "C", "P": return c + 6;
         default:  return 6;
      endcase
   endfunction

   task automatic run_op(int idx);
      logic [7:0]        op;
      logic [31:0]       a, b, c;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] got;
      string             name;
      int                k;
      op = op_q[idx];
      a = fa_q[idx];
      b = fb_q[idx];
      c = fc_q[idx];
      name = $sformatf("t%0d_%c", idx, op);
      test_errs = 0;
      case (op)
         "W": host_write(a[ADDR_W-1:0], b, got);
         "R": begin
            host_read(a[ADDR_W-1:0], got);
            check_word(name, b, got);  // literal from the trace
         end
         "U": begin
            host_write(a[ADDR_W-1:0], b, got);
            check_word(name, c, got);  // old word, read before write
         end
         "X": begin
            for (k = 0; k < b; k++) begin
               adr = a[ADDR_W-1:0] + k[ADDR_W-1:0];
               host_write(adr, $urandom, got);
            end
         end
         "M": begin
            for (k = 0; k < b; k++) begin
               adr = a[ADDR_W-1:0] + k[ADDR_W-1:0];
               host_read(adr, got);
               check_word(name, model[adr], got);
            end
         end
         "C": run_copy(name, a[ADDR_W-1:0], b[ADDR_W-1:0], c[ADDR_W:0], 1'b0, '0, '0);
         "P": run_copy(name, a[ADDR_W-1:0], b[ADDR_W-1:0], c[ADDR_W:0], 1'b1,
                       fd_q[idx][ADDR_W-1:0], fe_q[idx]);
         "N": zero_start(name, a[ADDR_W-1:0], b[ADDR_W-1:0]);
         default: begin
            $display("%s: unknown operation in trace", name);
            test_errs++;
            errors++;
         end
      endcase
      step_clk;  // idle gap between tests
      tests++;
      if (test_errs == 0) begin
         $display("pass %s", name);
      end else begin
         failed_tests++;
         $display("test %s failed with %0d errors", name, test_errs);
      end
   endtask

   initial begin
      rnd = $urandom(75);  // seed once
      arst_n_i = 1'b0;
      host_i = '0;
      start_i = 1'b0;
      cmd_i = '0;
      load_trace;
      if (!trace_ok) begin
         $display("trace could not be loaded, nothing was run");
         $display("TESTBENCH FAILED");
         $finish;
      end else begin
         foreach (op_q[i])
            limit += 2 * op_cost(op_q[i], fb_q[i], fc_q[i]);
         limit_on = 1'b1;
         repeat (4) @(posedge clk_i);  // reset for 4 cycles
         #2;
         arst_n_i = 1'b1;
         step_clk;
         foreach (op_q[i])
            run_op(i);
         $display("tests %0d, failed %0d, checks %0d, errors %0d",
                  tests, failed_tests, checks, errors);
         if (errors == 0) begin
            $display("TESTBENCH PASSED");
         end else begin
            $display("TESTBENCH FAILED");
         end
         $finish;
      end
   end

endmodule

//--- verification/blkcpy_trace.txt
# all fields hex: W adr dat | R adr exp | U adr new old | X adr cnt random fill
# M adr cnt check against model | C src dst len | N src dst 0 | P src dst len adr dat
# host write then read back
W 10 deadbeef
R 10 deadbeef
W 11 12345678
R 11 12345678
W 12 00000000
R 12 00000000
# write strobe returns the old word
U 10 cafef00d deadbeef
R 10 cafef00d
U 11 ffffffff 12345678
U 11 a5a5a5a5 ffffffff
R 11 a5a5a5a5
# random source block and guard words around the destination
X 20 10
M 20 10
X 58 08
X 60 08
X 68 08
# eight word copy, neighbours untouched
C 20 60 8
M 60 8
M 58 8
M 68 8
# single word copy
X 40 10
X 7f 3
C 40 80 1
M 7f 3
# long copy into low memory
X a0 20
X 00 22
C a0 00 20
M 00 22
# source wraps past the top of memory
X fc 4
X d0 8
C fc d0 8
M d0 8
# zero length start does nothing
N 20 60 0
M 60 8
# host write while busy is dropped
X e0 4
X 30 1
P 40 e0 4 41 0badf00d
M e0 4
M 41 1
P 20 e8 4 30 11111111
M e8 4
M 30 1
M 20 10

//--- tb.f
design/blkcpy_pkg.sv
design/dpsram_rbw.sv
design/copy_counter.sv
design/copy_fsm.sv
design/mem_port_steer.sv
design/blkcpy_top.sv
verification/blkcpy_tb.sv
